// File: Makefile
TOOL     = verilator
FLAGS    = --timing
TOP      = tbMips
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: build.f
mipsPkg.sv
mipsIf.sv
instrFetch.sv
decodeStage.sv
hazardForward.sv
executeStage.sv
memoryStage.sv
mipsCore.sv
tbMips.sv

// File: decodeStage.sv
module decodeStage (
    input  logic                             Clock,
    input  logic                             rst,
    input  mipsPkg::instrWordT               instr,
    input  logic [mipsPkg::DataWidth-1:0]    pcPlus4,
    input  logic                             valid,
    input  logic                             stall,
    input  logic                             branchTaken,
    input  logic                             wbEn,
    input  logic [mipsPkg::RegAddrWidth-1:0] wbReg,
    input  logic [mipsPkg::DataWidth-1:0]    wbData,
    idExIf.source                            idEx
);
    import mipsPkg::*;

    logic [DataWidth-1:0]    regs [2**RegAddrWidth];
    logic [2:0]              decAluCtl;
    logic                    decAluSrcImm;
    logic                    decMemRead;
    logic                    decMemWrite;
    logic                    decRegWrite;
    logic                    decIsBranch;
    logic                    decBranchNe;
    logic [RegAddrWidth-1:0] decDest;
    logic [DataWidth-1:0]    rsData;
    logic [DataWidth-1:0]    rtData;
    logic                    issue;

    // ------------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------------
    always_comb begin
        decAluCtl    = AluAdd;
        decAluSrcImm = 1'b0;
        decMemRead   = 1'b0;
        decMemWrite  = 1'b0;
        decRegWrite  = 1'b0;
        decIsBranch  = 1'b0;
        decBranchNe  = 1'b0;
        decDest      = instr.iType.rt;
        case (instr.rType.opcode)
            OpRType: begin
                decDest     = instr.rType.rd;
                decRegWrite = 1'b1;
                case (instr.rType.funct)
                    FnAdd:   decAluCtl = AluAdd;
                    FnSub:   decAluCtl = AluSub;
                    FnAnd:   decAluCtl = AluAnd;
                    FnOr:    decAluCtl = AluOr;
                    FnSlt:   decAluCtl = AluSlt;
                    default: decRegWrite = 1'b0;
                endcase
            end
            OpAddi: begin
                decAluSrcImm = 1'b1;
                decRegWrite  = 1'b1;
            end
            OpLw: begin
                decAluSrcImm = 1'b1;
                decMemRead   = 1'b1;
                decRegWrite  = 1'b1;
            end
            OpSw: begin
                decAluSrcImm = 1'b1;
                decMemWrite  = 1'b1;
            end
            OpBeq: decIsBranch = 1'b1;
            OpBne: begin
                decIsBranch = 1'b1;
                decBranchNe = 1'b1;
            end
            default: ;
        endcase
    end

    // Register file, write-through on the write-back port
    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < 2**RegAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbReg != '0) begin
            regs[wbReg] <= wbData;
        end
    end

    assign rsData = (wbEn && wbReg == instr.rType.rs) ? wbData : regs[instr.rType.rs];
    assign rtData = (wbEn && wbReg == instr.rType.rt) ? wbData : regs[instr.rType.rt];

    // ------------------------------------------------------------------
    // ID/EX register, bubble on stall or redirect
    // ------------------------------------------------------------------
    assign issue = valid && !stall && !branchTaken;

    always_ff @(posedge Clock) begin
        if (rst) begin
            idEx.valid    <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.regWrite <= 1'b0;
            idEx.isBranch <= 1'b0;
        end else begin
            idEx.valid    <= issue;
            idEx.memRead  <= issue && decMemRead;
            idEx.memWrite <= issue && decMemWrite;
            idEx.regWrite <= issue && decRegWrite;
            idEx.isBranch <= issue && decIsBranch;
        end
    end

    always_ff @(posedge Clock) begin
        idEx.aluCtl    <= decAluCtl;
        idEx.aluSrcImm <= decAluSrcImm;
        idEx.branchNe  <= decBranchNe;
        idEx.rs        <= instr.rType.rs;
        idEx.rt        <= instr.rType.rt;
        idEx.dest      <= decDest;
        idEx.rsData    <= rsData;
        idEx.rtData    <= rtData;
        idEx.imm       <= {{(DataWidth-16){instr.iType.imm[15]}}, instr.iType.imm};
        idEx.pcPlus4   <= pcPlus4;
    end

endmodule

// File: executeStage.sv
module executeStage (
    input  logic                          Clock,
    input  logic                          rst,
    idExIf.sink                           idEx,
    input  logic [1:0]                    fwdA,
    input  logic [1:0]                    fwdB,
    input  logic [mipsPkg::DataWidth-1:0] wbData,
    exMemIf.source                        exMem,
    output logic                          branchTaken,
    output logic [mipsPkg::DataWidth-1:0] branchTarget
);
    import mipsPkg::*;

    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] rtFwd;
    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] aluResult;

    // ------------------------------------------------------------------
    // Operand forwarding
    // ------------------------------------------------------------------
    always_comb begin
        case (fwdA)
            FwdExMem: opA = exMem.aluResult;
            FwdMemWb: opA = wbData;
            default:  opA = idEx.rsData;
        endcase
        case (fwdB)
            FwdExMem: rtFwd = exMem.aluResult;
            FwdMemWb: rtFwd = wbData;
            default:  rtFwd = idEx.rtData;
        endcase
    end

    assign opB = idEx.aluSrcImm ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.aluCtl)
            AluSub:  aluResult = opA - opB;
            AluAnd:  aluResult = opA & opB;
            AluOr:   aluResult = opA | opB;
            AluSlt:  aluResult = {{(DataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    // Branch resolves here, compare uses the forwarded rt value
    assign branchTaken  = idEx.valid && idEx.isBranch && ((opA == rtFwd) != idEx.branchNe);
    assign branchTarget = idEx.pcPlus4 + {idEx.imm[DataWidth-3:0], 2'b00};

    // EX/MEM register
    always_ff @(posedge Clock) begin
        if (rst) begin
            exMem.valid    <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.regWrite <= 1'b0;
        end else begin
            exMem.valid    <= idEx.valid;
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
            exMem.regWrite <= idEx.regWrite;
        end
    end

    always_ff @(posedge Clock) begin
        exMem.dest      <= idEx.dest;
        exMem.aluResult <= aluResult;
        exMem.storeData <= rtFwd;
    end

endmodule

// File: hazardForward.sv
module hazardForward (
    input  logic [mipsPkg::RegAddrWidth-1:0] ifRs,
    input  logic [mipsPkg::RegAddrWidth-1:0] ifRt,
    input  logic                             ifValid,
    idExIf.monitor                           idEx,
    exMemIf.monitor                          exMem,
    input  logic                             wbEn,
    input  logic [mipsPkg::RegAddrWidth-1:0] wbReg,
    output logic                             stall,
    output logic [1:0]                       fwdA,
    output logic [1:0]                       fwdB
);
    import mipsPkg::*;

    // Newest producer wins, r0 never forwarded
    function automatic logic [1:0] pickFwd(input logic [RegAddrWidth-1:0] src);
        logic [1:0] sel;
        sel = FwdNone;
        if (src != '0) begin
            if (exMem.regWrite && exMem.dest == src) begin
                sel = FwdExMem;
            end else if (wbEn && wbReg == src) begin
                sel = FwdMemWb;
            end
        end
        return sel;
    endfunction

    // Load in EX feeding the instruction in decode
    assign stall = ifValid && idEx.valid && idEx.memRead && idEx.dest != '0
                   && (idEx.dest == ifRs || idEx.dest == ifRt);

    assign fwdA = pickFwd(idEx.rs);
    assign fwdB = pickFwd(idEx.rt);

endmodule

// File: instrFetch.sv
module instrFetch (
    input  logic                              Clock,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              stall,
    input  logic                              branchTaken,
    input  logic [mipsPkg::DataWidth-1:0]     branchTarget,
    input  logic                              imemWe,
    input  logic [mipsPkg::ImemAddrWidth-1:0] imemAddr,
    input  mipsPkg::instrWordT                imemData,
    output mipsPkg::instrWordT                instr,
    output logic [mipsPkg::DataWidth-1:0]     pcPlus4,
    output logic                              valid
);
    import mipsPkg::*;

    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] pcNext;
    instrWordT            imem [ImemDepth];

    assign pcNext = pc + 32'd4;

    // Loader port stays live through reset
    always_ff @(posedge Clock) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    // PC and IF/ID valid. A redirect beats a stall
    always_ff @(posedge Clock) begin
        if (rst || !run) begin
            pc    <= '0;
            valid <= 1'b0;
        end else if (branchTaken) begin
            pc    <= branchTarget;
            valid <= 1'b0;
        end else if (!stall) begin
            pc    <= pcNext;
            valid <= 1'b1;
        end
    end

    // IF/ID payload, word-indexed fetch
    always_ff @(posedge Clock) begin
        if (!stall) begin
            instr   <= imem[pc[ImemAddrWidth+1:2]];
            pcPlus4 <= pcNext;
        end
    end

endmodule

// File: memoryStage.sv
module memoryStage (
    input  logic                              Clock,
    input  logic                              rst,
    exMemIf.sink                              exMem,
    output logic                              wbEn,
    output logic [mipsPkg::RegAddrWidth-1:0]  wbReg,
    output logic [mipsPkg::DataWidth-1:0]     wbData,
    output logic                              storeValid,
    output logic [mipsPkg::DmemAddrWidth-1:0] storeAddr,
    output logic [mipsPkg::DataWidth-1:0]     storeData
);
    import mipsPkg::*;

    logic [DataWidth-1:0]     dmem [DmemDepth];
    logic [DmemAddrWidth-1:0] dmemAddr;

    // Word index of the byte address
    assign dmemAddr = exMem.aluResult[DmemAddrWidth+1:2];

    assign storeValid = exMem.valid && exMem.memWrite;
    assign storeAddr  = dmemAddr;
    assign storeData  = exMem.storeData;

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < DmemDepth; i++) begin
                dmem[i] <= '0;
            end
        end else if (storeValid) begin
            dmem[dmemAddr] <= exMem.storeData;
        end
    end

    // MEM/WB register with write-back select
    always_ff @(posedge Clock) begin
        if (rst) begin
            wbEn <= 1'b0;
        end else begin
            wbEn <= exMem.valid && exMem.regWrite && exMem.dest != '0;
        end
    end

    always_ff @(posedge Clock) begin
        wbReg  <= exMem.dest;
        wbData <= exMem.memRead ? dmem[dmemAddr] : exMem.aluResult;
    end

endmodule

// File: mipsCore.sv
module mipsCore (
    input  logic                              Clock,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              imemWe,
    input  logic [mipsPkg::ImemAddrWidth-1:0] imemAddr,
    input  mipsPkg::instrWordT                imemData,
    output logic                              wbValid,
    output logic [mipsPkg::RegAddrWidth-1:0]  wbReg,
    output logic [mipsPkg::DataWidth-1:0]     wbData,
    output logic                              storeValid,
    output logic [mipsPkg::DmemAddrWidth-1:0] storeAddr,
    output logic [mipsPkg::DataWidth-1:0]     storeData
);
    import mipsPkg::*;

    // IF/ID contents
    instrWordT            ifInstr;
    logic [DataWidth-1:0] ifPcPlus4;
    logic                 ifValid;

    // Hazard and redirect controls
    logic                 stall;
    logic                 branchTaken;
    logic [DataWidth-1:0] branchTarget;
    logic [1:0]           fwdA;
    logic [1:0]           fwdB;

    idExIf  idEx ();
    exMemIf exMem ();

    instrFetch fetch0 (
        .Clock(Clock), .rst(rst), .run(run),
        .stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .instr(ifInstr), .pcPlus4(ifPcPlus4), .valid(ifValid)
    );

    decodeStage decode0 (
        .Clock(Clock), .rst(rst),
        .instr(ifInstr), .pcPlus4(ifPcPlus4), .valid(ifValid),
        .stall(stall), .branchTaken(branchTaken),
        .wbEn(wbValid), .wbReg(wbReg), .wbData(wbData),
        .idEx(idEx)
    );

    hazardForward hazard0 (
        .ifRs(ifInstr.rType.rs), .ifRt(ifInstr.rType.rt), .ifValid(ifValid),
        .idEx(idEx), .exMem(exMem),
        .wbEn(wbValid), .wbReg(wbReg),
        .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
    );

    executeStage execute0 (
        .Clock(Clock), .rst(rst), .idEx(idEx),
        .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
        .exMem(exMem), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    memoryStage memory0 (
        .Clock(Clock), .rst(rst), .exMem(exMem),
        .wbEn(wbValid), .wbReg(wbReg), .wbData(wbData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

endmodule

// File: mipsIf.sv
// ID/EX stage register contents
interface idExIf;
    import mipsPkg::*;

    logic                    valid;
    logic [2:0]              aluCtl;
    logic                    aluSrcImm;
    logic                    memRead;
    logic                    memWrite;
    logic                    regWrite;
    logic                    isBranch;
    logic                    branchNe;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [RegAddrWidth-1:0] dest;
    logic [DataWidth-1:0]    rsData;
    logic [DataWidth-1:0]    rtData;
    logic [DataWidth-1:0]    imm;
    logic [DataWidth-1:0]    pcPlus4;

    modport source (output valid, aluCtl, aluSrcImm, memRead, memWrite, regWrite,
                    isBranch, branchNe, rs, rt, dest, rsData, rtData, imm, pcPlus4);
    modport sink (input valid, aluCtl, aluSrcImm, memRead, memWrite, regWrite,
                  isBranch, branchNe, rs, rt, dest, rsData, rtData, imm, pcPlus4);
    // Hazard unit only looks at register names and the load flag
    modport monitor (input valid, memRead, rs, rt, dest);
endinterface

// EX/MEM stage register contents
interface exMemIf;
    import mipsPkg::*;

    logic                    valid;
    logic                    memRead;
    logic                    memWrite;
    logic                    regWrite;
    logic [RegAddrWidth-1:0] dest;
    logic [DataWidth-1:0]    aluResult;
    logic [DataWidth-1:0]    storeData;

    modport source (output valid, memRead, memWrite, regWrite, dest, aluResult, storeData);
    modport sink (input valid, memRead, memWrite, regWrite, dest, aluResult, storeData);
    modport monitor (input regWrite, dest);
endinterface

// File: mipsPkg.sv
package mipsPkg;

    // ------------------------------------------------------------------
    // Widths and memory sizes
    // ------------------------------------------------------------------
    localparam int DataWidth     = 32;
    localparam int RegAddrWidth  = 5;
    localparam int ImemDepth     = 64;
    localparam int ImemAddrWidth = 6;
    localparam int DmemDepth     = 64;
    localparam int DmemAddrWidth = 6;

    // Primary opcodes
    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpAddi  = 6'h08;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2b;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;

    // R-type function field
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr  = 6'h25;
    localparam logic [5:0] FnSlt = 6'h2a;

    // ALU operation, decode to execute
    localparam logic [2:0] AluAdd = 3'd0;
    localparam logic [2:0] AluSub = 3'd1;
    localparam logic [2:0] AluAnd = 3'd2;
    localparam logic [2:0] AluOr  = 3'd3;
    localparam logic [2:0] AluSlt = 3'd4;

    // Operand source selects for EX
    localparam logic [1:0] FwdNone  = 2'd0;
    localparam logic [1:0] FwdExMem = 2'd1;
    localparam logic [1:0] FwdMemWb = 2'd2;

    // ------------------------------------------------------------------
    // Instruction word, R and I format views
    // ------------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWordT;

endpackage

// File: tbMips.sv
module tbMips;
    import mipsPkg::*;

    localparam int Seed           = 32'h02ac44a9;
    localparam int ClockPeriod    = 100;
    localparam int ResetCycles    = 8;
    localparam int ProgLen        = 48;
    localparam int ProgCount      = 3;
    localparam int TailCycles     = 30;
    localparam int WatchdogCycles = ProgCount * (ProgLen * 4 + 60);

    logic                     Clock = 1'b0;
    logic                     rst;
    logic                     run;
    logic                     imemWe;
    logic [ImemAddrWidth-1:0] imemAddr;
    instrWordT                imemData;
    logic                     wbValid;
    logic [RegAddrWidth-1:0]  wbReg;
    logic [DataWidth-1:0]     wbData;
    logic                     storeValid;
    logic [DmemAddrWidth-1:0] storeAddr;
    logic [DataWidth-1:0]     storeData;

    // Program image and ISA model state
    instrWordT            prog [ProgLen+1];
    logic [DataWidth-1:0] modelRegs [2**RegAddrWidth];
    logic [DataWidth-1:0] modelMem [DmemDepth];
    int                   haltCycle;

    // Expected retirement events in program order
    logic [RegAddrWidth-1:0]  expWbReg [$];
    logic [DataWidth-1:0]     expWbData [$];
    logic [DmemAddrWidth-1:0] expStAddr [$];
    logic [DataWidth-1:0]     expStData [$];

    mipsCore dut0 (
        .Clock(Clock), .rst(rst), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic checkWb(input logic [RegAddrWidth-1:0] gotReg,
                           input logic [DataWidth-1:0] gotData);
        logic [RegAddrWidth-1:0] expReg;
        logic [DataWidth-1:0]    expData;
        if (expWbReg.size() == 0) begin
            failRun($sformatf("Unexpected register write to r%0d", gotReg));
        end else begin
            expReg  = expWbReg.pop_front();
            expData = expWbData.pop_front();
            if (gotReg !== expReg) begin
                failRun($sformatf("Mismatch wbReg: got %h expected %h", gotReg, expReg));
            end else if (gotData !== expData) begin
                failRun($sformatf("Mismatch wbData: got %h expected %h", gotData, expData));
            end
        end
    endtask

    task automatic checkStore(input logic [DmemAddrWidth-1:0] gotAddr,
                              input logic [DataWidth-1:0] gotData);
        logic [DmemAddrWidth-1:0] expAddr;
        logic [DataWidth-1:0]     expData;
        if (expStAddr.size() == 0) begin
            failRun($sformatf("Unexpected store to word %0d", gotAddr));
        end else begin
            expAddr = expStAddr.pop_front();
            expData = expStData.pop_front();
            if (gotAddr !== expAddr) begin
                failRun($sformatf("Mismatch storeAddr: got %h expected %h", gotAddr, expAddr));
            end else if (gotData !== expData) begin
                failRun($sformatf("Mismatch storeData: got %h expected %h", gotData, expData));
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Program builder
    // ------------------------------------------------------------------
    function automatic instrWordT makeRType(input logic [5:0] funct, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        instrWordT w;
        w.rType.opcode = OpRType;
        w.rType.rs     = rs;
        w.rType.rt     = rt;
        w.rType.rd     = rd;
        w.rType.shamt  = '0;
        w.rType.funct  = funct;
        return w;
    endfunction

    function automatic instrWordT makeIType(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        instrWordT w;
        w.iType.opcode = op;
        w.iType.rs     = rs;
        w.iType.rt     = rt;
        w.iType.imm    = imm;
        return w;
    endfunction

    // Small register range so that neighbours collide
    function automatic logic [4:0] pickReg();
        logic [31:0] v;
        v = $urandom % 16;
        if (v != 0) begin
            v = 32'd1 + v % 32'd7;
        end
        return v[4:0];
    endfunction

    function automatic logic [5:0] pickFunct();
        logic [31:0] v;
        logic [5:0]  fn;
        v = $urandom % 5;
        case (v)
            0:       fn = FnAdd;
            1:       fn = FnSub;
            2:       fn = FnAnd;
            3:       fn = FnOr;
            default: fn = FnSlt;
        endcase
        return fn;
    endfunction

    task automatic genProgram();
        int unsigned kind;
        logic [31:0] v;
        int          off;
        for (int i = 0; i < ProgLen; i++) begin
            kind = $urandom % 12;
            v    = $urandom;
            if (kind < 4) begin
                prog[i] = makeRType(pickFunct(), pickReg(), pickReg(), pickReg());
            end else if (kind < 6) begin
                prog[i] = makeIType(OpAddi, pickReg(), pickReg(), v[15:0]);
            end else if (kind < 10) begin
                // Base r0 with an offset into the first 16 words
                v       = (v % 16) * 4;
                prog[i] = makeIType(kind < 8 ? OpLw : OpSw, 5'd0, pickReg(), v[15:0]);
            end else begin
                off = 1 + int'(v % 3);
                // Never jump past the halt word
                if (off > ProgLen - 1 - i) begin
                    off = ProgLen - 1 - i;
                end
                prog[i] = makeIType(kind == 10 ? OpBeq : OpBne, pickReg(), pickReg(), off[15:0]);
            end
        end
        prog[ProgLen] = makeIType(OpBeq, 5'd0, 5'd0, 16'hffff);
    endtask

    // ------------------------------------------------------------------
    // ISA model
    // ------------------------------------------------------------------
    task automatic writeReg(input logic [RegAddrWidth-1:0] dest, input logic [DataWidth-1:0] val);
        if (dest != '0) begin
            modelRegs[dest] = val;
            expWbReg.push_back(dest);
            expWbData.push_back(val);
        end
    endtask

    task automatic runModel();
        instrWordT               w;
        logic [DataWidth-1:0]    rsV;
        logic [DataWidth-1:0]    rtV;
        logic [DataWidth-1:0]    immV;
        logic [DataWidth-1:0]    sum;
        logic [DataWidth-1:0]    res;
        logic [RegAddrWidth-1:0] loadDest;
        int                      pcIdx;
        int                      nextIdx;
        int                      cycle;
        expWbReg.delete();
        expWbData.delete();
        expStAddr.delete();
        expStData.delete();
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        foreach (modelMem[i]) begin
            modelMem[i] = '0;
        end
        pcIdx    = 0;
        cycle    = 0;
        loadDest = '0;
        while (pcIdx < ProgLen) begin
            w = prog[pcIdx];
            // Load-use bubble counts on either source field
            if (loadDest != '0 && (w.rType.rs == loadDest || w.rType.rt == loadDest)) begin
                cycle++;
            end
            loadDest = '0;
            cycle++;
            rsV     = modelRegs[w.iType.rs];
            rtV     = modelRegs[w.iType.rt];
            immV    = {{(DataWidth-16){w.iType.imm[15]}}, w.iType.imm};
            sum     = rsV + immV;
            nextIdx = pcIdx + 1;
            case (w.iType.opcode)
                OpRType: begin
                    case (w.rType.funct)
                        FnAdd:   res = rsV + rtV;
                        FnSub:   res = rsV - rtV;
                        FnAnd:   res = rsV & rtV;
                        FnOr:    res = rsV | rtV;
                        default: res = {{(DataWidth-1){1'b0}}, $signed(rsV) < $signed(rtV)};
                    endcase
                    writeReg(w.rType.rd, res);
                end
                OpAddi: writeReg(w.iType.rt, sum);
                OpLw: begin
                    writeReg(w.iType.rt, modelMem[sum[DmemAddrWidth+1:2]]);
                    loadDest = w.iType.rt;
                end
                OpSw: begin
                    modelMem[sum[DmemAddrWidth+1:2]] = rtV;
                    expStAddr.push_back(sum[DmemAddrWidth+1:2]);
                    expStData.push_back(rtV);
                end
                default: begin
                    if ((rsV == rtV) == (w.iType.opcode == OpBeq)) begin
                        nextIdx = pcIdx + 1 + int'(w.iType.imm);
                        cycle += 2;
                    end
                end
            endcase
            pcIdx = nextIdx;
        end
        haltCycle = cycle;
    endtask

    // Reset covers the first cycles of the load and run stays low throughout
    task automatic loadProgram();
        rst    = 1'b1;
        run    = 1'b0;
        imemWe = 1'b1;
        for (int i = 0; i <= ProgLen; i++) begin
            imemAddr = i[ImemAddrWidth-1:0];
            imemData = prog[i];
            @(posedge Clock);
            #1;
            if (i == ResetCycles - 1) begin
                rst = 1'b0;
            end
        end
        imemWe = 1'b0;
    endtask

    always @(negedge Clock) begin
        if (!rst && wbValid) begin
            checkWb(wbReg, wbData);
        end
        if (!rst && storeValid) begin
            checkStore(storeAddr, storeData);
        end
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        failRun("Watchdog expired before all programs finished");
    end

    initial begin
        int missing;
        int progIdx;
        rst      = 1'b1;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        void'($urandom(Seed));
        missing  = 0;
        progIdx  = 0;
        while (progIdx < ProgCount && missing == 0) begin
            genProgram();
            runModel();
            loadProgram();
            run = 1'b1;
            repeat (haltCycle + TailCycles) @(posedge Clock);
            #1;
            missing = expWbReg.size() + expStAddr.size();
            progIdx++;
        end
        if (missing != 0) begin
            failRun($sformatf("Program %0d ended with %0d expected events never seen",
                              progIdx - 1, missing));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
